//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_obj_tile_renderer
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hw/obj_pkg.sv
hw/tile_fetch.sv
hw/tile_pixel_store.sv
hw/zoom_step.sv
hw/fb_row_writer.sv
hw/obj_tile_renderer.sv
test/obj_assertions.sv
test/tb_obj_tile_renderer.sv

//--- hw/fb_row_writer.sv
`timescale 1ns/1ns

module fb_row_writer
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  obj_req_t              job,
    input  logic                  job_start,
    input  logic                  load_done,
    input  logic                  job_dropped,
    input  zoom_map_t             row_map,
    input  zoom_map_t             col_map,
    input  logic                  row_ready,
    input  logic                  col_ready,
    output logic [3:0]            store_rd_row,
    input  pixel_t [TILE_DIM-1:0] store_rd_pixels,
    output fb_wb_req_t            fb_wb,
    input  logic                  fb_ack,
    output logic                  draw_done
);

    typedef enum logic [1:0] {W_IDLE, W_BUILD, W_WRITE} state_t;

    state_t                 state;
    logic                   load_seen;
    logic [3:0]             row;
    logic [2:0]             word;
    logic                   last_row;
    logic                   writing;
    pixel_t [ROW_SLOTS-1:0] slots;
    pixel_t [ROW_SLOTS-1:0] next_slots;
    logic [14:0]            word_adr;
    logic [63:0]            word_dat;
    logic [7:0]             word_sel;

    assign store_rd_row = row_map.indices[row] ^ {4{job.flip_y}};
    assign last_row     = ({1'b0, row} == row_map.count - 5'd1);
    assign writing      = (state == W_WRITE);

    // kept columns land left-aligned, then shifted by the sub-word part of x
    always_comb begin
        next_slots = '0;
        for (int c = 0; c < TILE_DIM; c++) begin
            if (col_map.valid[c]) begin
                next_slots[c + job.x[1:0]] =
                    store_rd_pixels[col_map.indices[c] ^ {4{job.flip_x}}];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == W_BUILD) begin
            slots <= next_slots;
        end
    end

    always_comb begin
        pixel_t pix;
        for (int k = 0; k < 4; k++) begin
            pix = slots[4 * word + k];
            if (job.bpp6) begin
                word_dat[16 * k +: 16] = {4'd0, job.color[7:2], pix};
            end else begin
                word_dat[16 * k +: 16] = {4'd0, job.color, pix[3:0]};
            end
            word_sel[2 * k +: 2] = {2{|pix}};
        end
    end

    assign word_adr = {job.y[7:0], 7'd0} + 15'(job.x[8:2]) + 15'({row, 7'd0}) + 15'(word);

    assign fb_wb = '{cyc: writing, stb: writing, we: writing,
                     adr: word_adr, dat: word_dat, sel: word_sel};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= W_IDLE;
            load_seen <= 1'b0;
            row       <= '0;
            word      <= '0;
            draw_done <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            if (job_start) begin
                load_seen <= 1'b0;
            end else if (load_done) begin
                load_seen <= 1'b1;
            end
            case (state)
                W_IDLE: begin
                    if (job_dropped) begin
                        draw_done <= 1'b1;
                    end else if ((load_seen | load_done) & row_ready & col_ready) begin
                        load_seen <= 1'b0;
                        row       <= '0;
                        // every row zoomed away, nothing to write
                        if (row_map.count == '0) begin
                            draw_done <= 1'b1;
                        end else begin
                            state <= W_BUILD;
                        end
                    end
                end
                W_BUILD: begin
                    word  <= '0;
                    state <= W_WRITE;
                end
                default: begin
                    if (fb_ack) begin
                        word <= word + 3'd1;
                        if (word == 3'(WORDS_PER_ROW - 1)) begin
                            if (last_row) begin
                                draw_done <= 1'b1;
                                state     <= W_IDLE;
                            end else begin
                                row   <= row + 4'd1;
                                state <= W_BUILD;
                            end
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/obj_pkg.sv
package obj_pkg;

    // tile geometry
    localparam int TILE_DIM      = 16;
    localparam int ROW_SLOTS     = 20;
    localparam int WORDS_PER_ROW = 5;

    // tile ROM words per tile
    localparam int BURST_4BPP = 16;
    localparam int BURST_6BPP = 32;

    // anything drawn past these limits is skipped
    localparam int CLIP_X = 480;
    localparam int CLIP_Y = 240;

    localparam int ZOOM_ONE = 256;

    // palette index, 0 is transparent
    typedef logic [5:0] pixel_t;

    typedef struct packed {
        logic [12:0] tile_code;
        logic [11:0] x;
        logic [11:0] y;
        logic [7:0]  color;
        logic [7:0]  zoom_x;
        logic [7:0]  zoom_y;
        logic        flip_x;
        logic        flip_y;
        logic        bpp6;
    } obj_req_t;

    // kept source indices along one axis
    typedef struct packed {
        logic [4:0]       count;
        logic [15:0]      valid;
        logic [15:0][3:0] indices;
    } zoom_map_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [17:0] adr;
    } rom_wb_req_t;

    // adr is the 64-bit word address, y * 128 + x / 4
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [14:0] adr;
        logic [63:0] dat;
        logic [7:0]  sel;
    } fb_wb_req_t;

endpackage

//--- hw/obj_tile_renderer.sv
`timescale 1ns/1ns

module obj_tile_renderer
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  obj_req_t    req,
    output logic        req_ready,
    output rom_wb_req_t rom_wb,
    input  logic [63:0] rom_dat,
    input  logic        rom_ack,
    output fb_wb_req_t  fb_wb,
    input  logic        fb_ack,
    output logic        draw_done
);

    obj_req_t              job;
    logic                  job_start;
    logic                  job_dropped;
    logic                  load_done;
    logic                  store_we;
    logic [3:0]            store_row;
    logic [1:0]            store_half_en;
    pixel_t [TILE_DIM-1:0] store_pixels;
    logic [3:0]            store_rd_row;
    pixel_t [TILE_DIM-1:0] store_rd_pixels;
    zoom_map_t             row_map;
    zoom_map_t             col_map;
    logic                  row_ready;
    logic                  col_ready;

    tile_fetch fetch (
        .clk, .reset,
        .req_valid, .req, .req_ready,
        .rom_wb, .rom_dat, .rom_ack,
        .job, .job_start,
        .store_we, .store_row, .store_half_en, .store_pixels,
        .load_done, .job_dropped,
        .draw_done
    );

    tile_pixel_store store (
        .clk,
        .we        (store_we),
        .wr_row    (store_row),
        .half_en   (store_half_en),
        .wr_pixels (store_pixels),
        .rd_row    (store_rd_row),
        .rd_pixels (store_rd_pixels)
    );

    zoom_step row_zoom (
        .clk, .reset,
        .start (job_start),
        .zoom  (job.zoom_y),
        .map   (row_map),
        .ready (row_ready)
    );

    zoom_step col_zoom (
        .clk, .reset,
        .start (job_start),
        .zoom  (job.zoom_x),
        .map   (col_map),
        .ready (col_ready)
    );

    fb_row_writer writer (
        .clk, .reset,
        .job, .job_start, .load_done, .job_dropped,
        .row_map, .col_map, .row_ready, .col_ready,
        .store_rd_row, .store_rd_pixels,
        .fb_wb, .fb_ack,
        .draw_done
    );

endmodule

//--- hw/tile_fetch.sv
`timescale 1ns/1ns

module tile_fetch
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_valid,
    input  obj_req_t              req,
    output logic                  req_ready,
    output rom_wb_req_t           rom_wb,
    input  logic [63:0]           rom_dat,
    input  logic                  rom_ack,
    output obj_req_t              job,
    output logic                  job_start,
    output logic                  store_we,
    output logic [3:0]            store_row,
    output logic [1:0]            store_half_en,
    output pixel_t [TILE_DIM-1:0] store_pixels,
    output logic                  load_done,
    output logic                  job_dropped,
    input  logic                  draw_done
);

    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_BUSY} state_t;

    state_t      state;
    logic        rom_cyc;
    logic [17:0] rom_adr;
    logic [4:0]  word;
    logic        accept;
    logic        drop;
    logic        last_word;

    // pixel k of a 6bpp half word: two high bits from 16+2k, nibble order 2,3,0,1
    function automatic pixel_t decode_6bpp(input logic [31:0] d, input logic [1:0] k);
        return {d[16 + 2 * k +: 2], d[4 * (k ^ 2'd2) +: 4]};
    endfunction

    assign req_ready = (state == S_IDLE);
    assign accept    = req_valid & req_ready;
    assign drop      = (req.tile_code == '0) || (req.x > CLIP_X) || (req.y > CLIP_Y);
    assign last_word = job.bpp6 ? (word == 5'(BURST_6BPP - 1)) : (word == 5'(BURST_4BPP - 1));

    assign rom_wb = '{cyc: rom_cyc, stb: rom_cyc, adr: rom_adr};

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            rom_cyc     <= 1'b0;
            word        <= '0;
            job_start   <= 1'b0;
            load_done   <= 1'b0;
            job_dropped <= 1'b0;
        end else begin
            job_start   <= 1'b0;
            load_done   <= 1'b0;
            job_dropped <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        job_start <= 1'b1;
                        word      <= '0;
                        if (drop) begin
                            job_dropped <= 1'b1;
                            state       <= S_BUSY;
                        end else begin
                            rom_cyc <= 1'b1;
                            state   <= S_FETCH;
                        end
                    end
                end
                S_FETCH: begin
                    if (rom_ack) begin
                        word <= word + 5'd1;
                        if (last_word) begin
                            rom_cyc   <= 1'b0;
                            load_done <= 1'b1;
                            state     <= S_BUSY;
                        end
                    end
                end
                default: begin
                    // store stays owned by this job until the writer is done
                    if (draw_done) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            job     <= req;
            rom_adr <= req.bpp6 ? {req.tile_code, 5'd0} : {1'b0, req.tile_code, 4'd0};
        end else if (state == S_FETCH && rom_ack) begin
            rom_adr <= rom_adr + 18'd1;
        end
    end

    // 4bpp fills a row per word, 6bpp fills half a row, even words on the left
    assign store_we      = (state == S_FETCH) & rom_ack;
    assign store_row     = job.bpp6 ? word[4:1] : word[3:0];
    assign store_half_en = job.bpp6 ? (word[0] ? 2'b10 : 2'b01) : 2'b11;

    always_comb begin
        for (int i = 0; i < TILE_DIM; i++) begin
            if (job.bpp6) begin
                store_pixels[i] = decode_6bpp(rom_dat[32 * ((i / 4) % 2) +: 32], 2'(i % 4));
            end else begin
                store_pixels[i] = {2'b00, rom_dat[4 * i +: 4]};
            end
        end
    end

endmodule

//--- hw/tile_pixel_store.sv
`timescale 1ns/1ns

module tile_pixel_store
    import obj_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [3:0]            wr_row,
    input  logic [1:0]            half_en,
    input  pixel_t [TILE_DIM-1:0] wr_pixels,
    input  logic [3:0]            rd_row,
    output pixel_t [TILE_DIM-1:0] rd_pixels
);

    localparam int HALF = TILE_DIM / 2;

    pixel_t [TILE_DIM-1:0] mem [TILE_DIM];

    // half_en[0] covers pixels 0..7, half_en[1] covers 8..15
    always_ff @(posedge clk) begin
        if (we) begin
            if (half_en[0]) begin
                mem[wr_row][HALF-1:0] <= wr_pixels[HALF-1:0];
            end
            if (half_en[1]) begin
                mem[wr_row][TILE_DIM-1:HALF] <= wr_pixels[TILE_DIM-1:HALF];
            end
        end
    end

    // whole row, no read latency
    assign rd_pixels = mem[rd_row];

endmodule

//--- hw/zoom_step.sv
`timescale 1ns/1ns

module zoom_step
    import obj_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  logic [7:0] zoom,
    output zoom_map_t map,
    output logic      ready
);

    logic       busy;
    logic [8:0] accum;
    logic [8:0] step;
    logic [8:0] next_accum;
    logic [3:0] index;

    assign next_accum = accum + step;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            ready <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            ready <= 1'b0;
        end else if (busy && index == 4'd15) begin
            busy  <= 1'b0;
            ready <= 1'b1;
        end
    end

    // one source index per cycle, kept whenever bit 8 toggles
    always_ff @(posedge clk) begin
        if (start) begin
            accum <= '0;
            step  <= 9'(ZOOM_ONE) - {1'b0, zoom};
            index <= '0;
            map   <= '0;
        end else if (busy) begin
            accum <= next_accum;
            index <= index + 4'd1;
            if (next_accum[8] != accum[8]) begin
                map.valid[map.count[3:0]]   <= 1'b1;
                map.indices[map.count[3:0]] <= index;
                map.count                   <= map.count + 5'd1;
            end
        end
    end

endmodule

//--- test/obj_assertions.sv
`timescale 1ns/1ns

module obj_assertions
    import obj_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        req_ready,
    input rom_wb_req_t rom_wb,
    input logic        rom_ack,
    input fb_wb_req_t  fb_wb,
    input logic        fb_ack
);

    rom_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        rom_wb.stb |-> rom_wb.cyc)
        else $error("rom stb high outside a cycle");

    fb_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        fb_wb.stb |-> fb_wb.cyc)
        else $error("fb stb high outside a cycle");

    // a strobed word is held until the slave acks it
    rom_adr_held: assert property (@(posedge clk) disable iff (reset)
        rom_wb.stb && !rom_ack |=> rom_wb.stb && $stable(rom_wb.adr))
        else $error("rom address dropped or changed before ack");

    fb_word_held: assert property (@(posedge clk) disable iff (reset)
        fb_wb.stb && !fb_ack |=> fb_wb.stb && $stable({fb_wb.adr, fb_wb.dat, fb_wb.sel}))
        else $error("fb word dropped or changed before ack");

    no_accept_in_fetch: assert property (@(posedge clk) disable iff (reset)
        rom_wb.cyc |-> !req_ready)
        else $error("request accepted during a tile fetch");

endmodule

bind obj_tile_renderer obj_assertions checks (
    .clk       (clk),
    .reset     (reset),
    .req_ready (req_ready),
    .rom_wb    (rom_wb),
    .rom_ack   (rom_ack),
    .fb_wb     (fb_wb),
    .fb_ack    (fb_ack)
);

//--- test/tb_obj_tile_renderer.sv
`timescale 1ns/1ns

module tb_obj_tile_renderer
    import obj_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_REQUESTS = 55;
    localparam int WATCHDOG_NS  = NUM_REQUESTS * 200 * 4 * CLK_PERIOD;
    // tile codes stay below 64, so 64 tiles of 32 words cover every fetch
    localparam int ROM_WORDS    = 2048;

    typedef int idx_q_t[$];

    logic        clk = 1'b0;
    logic        reset;
    logic        req_valid;
    obj_req_t    req;
    logic        req_ready;
    rom_wb_req_t rom_wb;
    logic [63:0] rom_dat = '0;
    logic        rom_ack = 1'b0;
    fb_wb_req_t  fb_wb;
    logic        fb_ack = 1'b0;
    logic        draw_done;

    int seed = 38;
    int rom_wait = 0;
    int fb_wait = 0;
    int done_count = 0;
    int n_requests = 0;
    int n_checks = 0;
    int n_errors = 0;

    logic [63:0] rom_mem [ROM_WORDS];
    int          rom_seen[$];
    int          rom_expected[$];
    fb_wb_req_t  fb_seen[$];
    fb_wb_req_t  fb_expected[$];

    obj_tile_renderer UUT (
        .clk, .reset,
        .req_valid, .req, .req_ready,
        .rom_wb, .rom_dat, .rom_ack,
        .fb_wb, .fb_ack,
        .draw_done
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // tile ROM slave, acks one word after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (reset) begin
            rom_ack <= 1'b0;
        end else if (rom_ack) begin
            rom_ack  <= 1'b0;
            rom_wait <= rand_below(4);
        end else if (rom_wb.cyc && rom_wb.stb) begin
            if (rom_wait == 0) begin
                rom_ack <= 1'b1;
                rom_dat <= rom_mem[rom_wb.adr[10:0]];
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            fb_ack <= 1'b0;
        end else if (fb_ack) begin
            fb_ack  <= 1'b0;
            fb_wait <= rand_below(4);
        end else if (fb_wb.cyc && fb_wb.stb) begin
            if (fb_wait == 0) begin
                fb_ack <= 1'b1;
            end else begin
                fb_wait <= fb_wait - 1;
            end
        end
    end

    // transfers are taken mid-cycle while ack and the request are both steady
    always @(negedge clk) begin
        if (rom_wb.stb && rom_ack) begin
            rom_seen.push_back(int'(rom_wb.adr));
        end
        if (fb_wb.stb && fb_ack) begin
            fb_seen.push_back(fb_wb);
        end
        if (draw_done) begin
            done_count++;
        end
    end

    function automatic bit is_dropped(input obj_req_t r);
        return (r.tile_code == '0) || (r.x > CLIP_X) || (r.y > CLIP_Y);
    endfunction

    // kept source indices of one axis
    function automatic idx_q_t zoom_list(input logic [7:0] zoom);
        idx_q_t kept;
        int step;
        int acc;
        int acc_next;
        step = ZOOM_ONE - int'(zoom);
        acc = 0;
        for (int i = 0; i < TILE_DIM; i++) begin
            acc_next = (acc + step) % 512;
            if ((acc_next >= 256) != (acc >= 256)) begin
                kept.push_back(i);
            end
            acc = acc_next;
        end
        return kept;
    endfunction

    function automatic pixel_t tile_pixel(input obj_req_t r, input int row, input int col);
        logic [63:0] w;
        logic [31:0] half;
        int k;
        int nib;
        if (!r.bpp6) begin
            w = rom_mem[11'(int'(r.tile_code) * BURST_4BPP + row)];
            return {2'b00, 4'(w >> (4 * col))};
        end
        // even word is the left half of the row
        w = rom_mem[11'(int'(r.tile_code) * BURST_6BPP + 2 * row + col / 8)];
        half = ((col % 8) < 4) ? w[31:0] : w[63:32];
        k = col % 4;
        case (k)
            0: nib = 2;
            1: nib = 3;
            2: nib = 0;
            default: nib = 1;
        endcase
        return {2'(half >> (16 + 2 * k)), 4'(half >> (4 * nib))};
    endfunction

    task automatic build_expected(input obj_req_t r);
        idx_q_t rows;
        idx_q_t cols;
        pixel_t slots [ROW_SLOTS];
        pixel_t pix;
        fb_wb_req_t wr;
        int burst;
        int src_row;
        int src_col;
        fb_expected.delete();
        rom_expected.delete();
        if (is_dropped(r)) begin
            return;
        end
        burst = r.bpp6 ? BURST_6BPP : BURST_4BPP;
        for (int i = 0; i < burst; i++) begin
            rom_expected.push_back(int'(r.tile_code) * burst + i);
        end
        rows = zoom_list(r.zoom_y);
        cols = zoom_list(r.zoom_x);
        foreach (rows[ri]) begin
            foreach (slots[s]) begin
                slots[s] = '0;
            end
            src_row = r.flip_y ? 15 - rows[ri] : rows[ri];
            foreach (cols[ci]) begin
                src_col = r.flip_x ? 15 - cols[ci] : cols[ci];
                slots[ci + int'(r.x[1:0])] = tile_pixel(r, src_row, src_col);
            end
            for (int w = 0; w < WORDS_PER_ROW; w++) begin
                wr = '0;
                wr.cyc = 1'b1;
                wr.stb = 1'b1;
                wr.we = 1'b1;
                wr.adr = 15'(int'(r.y) * 128 + int'(r.x) / 4 + ri * 128 + w);
                for (int k = 0; k < 4; k++) begin
                    pix = slots[4 * w + k];
                    wr.dat[16 * k +: 16] = r.bpp6 ? {4'd0, r.color[7:2], pix}
                                                  : {4'd0, r.color, pix[3:0]};
                    wr.sel[2 * k +: 2] = (pix != '0) ? 2'b11 : 2'b00;
                end
                fb_expected.push_back(wr);
            end
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        n_checks++;
        if (actual != expected) begin
            n_errors++;
            $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, what, expected, actual);
        end
    endtask

    task automatic check_fb_word(input string what, input fb_wb_req_t expected,
                                 input fb_wb_req_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] time %0t: %s expected/got adr %h/%h dat %h/%h sel %b/%b we %b/%b",
                     $time, what, expected.adr, actual.adr, expected.dat, actual.dat,
                     expected.sel, actual.sel, expected.we, actual.we);
        end
    endtask

    function automatic obj_req_t make_request(input logic [12:0] tile, input logic [11:0] x,
                                              input logic [11:0] y, input logic [7:0] color,
                                              input logic [7:0] zoom_x, input logic [7:0] zoom_y,
                                              input logic flip_x, input logic flip_y,
                                              input logic bpp6);
        obj_req_t r;
        r = '{tile_code: tile, x: x, y: y, color: color, zoom_x: zoom_x, zoom_y: zoom_y,
              flip_x: flip_x, flip_y: flip_y, bpp6: bpp6};
        return r;
    endfunction

    function automatic obj_req_t random_request();
        obj_req_t r;
        r.tile_code = 13'(rand_below(63) + 1);
        r.x = 12'(rand_below(CLIP_X + 1));
        r.y = 12'(rand_below(CLIP_Y + 1));
        r.color = 8'(rand_below(256));
        r.zoom_x = (rand_below(2) == 0) ? 8'd0 : 8'(rand_below(256));
        r.zoom_y = (rand_below(2) == 0) ? 8'd0 : 8'(rand_below(256));
        r.flip_x = 1'(rand_below(2));
        r.flip_y = 1'(rand_below(2));
        r.bpp6 = 1'(rand_below(2));
        // an occasional request that must be skipped
        case (rand_below(10))
            0: r.tile_code = '0;
            1: r.x = 12'(CLIP_X + 1 + rand_below(1000));
            2: r.y = 12'(CLIP_Y + 1 + rand_below(1000));
            default: ;
        endcase
        return r;
    endfunction

    task automatic run_request(input obj_req_t r);
        int n;
        build_expected(r);
        rom_seen.delete();
        fb_seen.delete();
        done_count = 0;
        @(posedge clk);
        req       <= r;
        req_valid <= 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        req_valid <= 1'b0;
        do @(negedge clk); while (!draw_done);
        // a late extra write or done pulse would land in this gap
        repeat (4) @(negedge clk);
        check_count("rom words", rom_expected.size(), rom_seen.size());
        n = (rom_seen.size() < rom_expected.size()) ? rom_seen.size() : rom_expected.size();
        for (int i = 0; i < n; i++) begin
            check_count($sformatf("rom adr of word %0d", i), rom_expected[i], rom_seen[i]);
        end
        check_count("fb writes", fb_expected.size(), fb_seen.size());
        n = (fb_seen.size() < fb_expected.size()) ? fb_seen.size() : fb_expected.size();
        for (int i = 0; i < n; i++) begin
            check_fb_word($sformatf("fb write %0d", i), fb_expected[i], fb_seen[i]);
        end
        check_count("draw_done pulses", 1, done_count);
        n_requests++;
    endtask

    task automatic report_test(input string name, input int err_mark, input int n_req);
        $display("test %s: %0d requests, %0d errors", name, n_req, n_errors - err_mark);
    endtask

    initial begin
        obj_req_t r;
        int err_mark;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom_mem[i] = {$random(seed), $random(seed)};
        end
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        err_mark = n_errors;
        r = make_request(13'd5, 12'd64, 12'd32, 8'h5a, 8'd0, 8'd0, 1'b0, 1'b0, 1'b0);
        run_request(r);
        check_count("aligned 4bpp writes", 80, fb_seen.size());
        report_test("aligned_4bpp", err_mark, 1);

        // all four flip combinations, x off the word grid
        err_mark = n_errors;
        for (int i = 0; i < 4; i++) begin
            r = random_request();
            r.tile_code = 13'(rand_below(63) + 1);
            r.x = 12'(4 * rand_below(120) + 1 + rand_below(3));
            r.y = 12'(rand_below(CLIP_Y + 1));
            r.zoom_x = 8'd0;
            r.zoom_y = 8'd0;
            r.flip_x = 1'(i % 2);
            r.flip_y = 1'(i / 2);
            r.bpp6 = 1'b0;
            run_request(r);
        end
        report_test("flip_shift", err_mark, 4);

        err_mark = n_errors;
        r = make_request(13'd41, 12'd202, 12'd117, 8'hc7, 8'd0, 8'd0, 1'b0, 1'b0, 1'b1);
        run_request(r);
        check_count("6bpp rom words", BURST_6BPP, rom_seen.size());
        report_test("bpp6", err_mark, 1);

        err_mark = n_errors;
        for (int i = 0; i < 6; i++) begin
            r = random_request();
            r.tile_code = 13'(rand_below(63) + 1);
            r.x = 12'(rand_below(CLIP_X + 1));
            r.y = 12'(rand_below(CLIP_Y + 1));
            r.zoom_x = 8'(rand_below(256));
            r.zoom_y = 8'(rand_below(256));
            run_request(r);
            check_count("zoomed writes", 5 * zoom_list(r.zoom_y).size(), fb_seen.size());
        end
        report_test("zoom", err_mark, 6);

        err_mark = n_errors;
        r = make_request(13'd0, 12'd100, 12'd100, 8'h11, 8'd0, 8'd0, 1'b0, 1'b0, 1'b0);
        run_request(r);
        r = make_request(13'd7, 12'(CLIP_X + 1), 12'd10, 8'h22, 8'd0, 8'd0, 1'b0, 1'b0, 1'b1);
        run_request(r);
        r = make_request(13'd9, 12'd10, 12'(CLIP_Y + 9), 8'h33, 8'd0, 8'd0, 1'b1, 1'b0, 1'b0);
        run_request(r);
        report_test("dropped", err_mark, 3);

        err_mark = n_errors;
        for (int i = 0; i < 40; i++) begin
            run_request(random_request());
        end
        report_test("random_run", err_mark, 40);

        $display("requests %0d, checks %0d, errors %0d", n_requests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns with %0d requests done", WATCHDOG_NS, n_requests);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
